/* compile.f */
+incdir+testbench
logic/csma_pkg.sv
logic/backoff_timer.sv
logic/frame_tx_fsm.sv
logic/bit_transmitter.sv
logic/frame_receiver.sv
logic/channel_model.sv
logic/csma_station.sv
logic/csma_link_top.sv
testbench/tb_csma_link.sv

/* testbench/tb_checks.svh */
//////////////////////////////////////////////////////////////////////
// testbench helpers for the csma/cd link
// fibonacci lfsr for request gaps, check and error counters,
// compare tasks for status, single-bit and count results
//////////////////////////////////////////////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count  = 0;
int value_errors = 0;
// timeouts and other non-value failures
int other_errors = 0;

// fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr_state = 32'hcc40d2ea;

function automatic logic next_lfsr_bit();
   logic fb;
   fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
   lfsr_state = {lfsr_state[30:0], fb};
   return fb;
endfunction

// one lfsr step per bit taken
function automatic int random_bits(input int width);
   int value;
   int i;
   value = 0;
   for (i = 0; i < width; i++)
      value = (value << 1) | int'(next_lfsr_bit());
   return value;
endfunction

task automatic compare_status(input string test, input string what,
                              input csma_pkg::status_t expected,
                              input csma_pkg::status_t actual);
   check_count++;
   if (actual !== expected)
   begin
      value_errors++;
      $display("error [%s] %s: expected %s, actual %s",
               test, what, expected.name(), actual.name());
   end
endtask

task automatic compare_bit(input string test, input string what,
                           input logic expected, input logic actual);
   check_count++;
   if (actual !== expected)
   begin
      value_errors++;
      $display("error [%s] %s: expected %b, actual %b", test, what, expected, actual);
   end
endtask

task automatic compare_count(input string test, input string what,
                             input int expected, input int actual);
   check_count++;
   if (actual != expected)
   begin
      value_errors++;
      $display("error [%s] %s: expected %0d, actual %0d", test, what, expected, actual);
   end
endtask

`endif

/* testbench/tb_csma_link.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the two-station csma/cd link
// clock, reset, event monitor with host auto acknowledge,
// watchdog, directed tests and the final report
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_csma_link;

   localparam int clk_period   = 40;
   localparam int frame_len    = csma_pkg::frame_len_default;
   localparam int max_attempts = csma_pkg::max_attempts_default;
   localparam int settle       = csma_pkg::settle_cycles_default;
   // decision, frame symbols, burst-done path, settle
   localparam int success_cycles = 1 + frame_len + 2 + settle;
   // one attempt lost to a collision, with the longest backoff
   localparam int attempt_cycles = 1 + 2 * frame_len + 2 + settle + 7;
   // room to defer behind one full frame of the other station
   localparam int req_bound = max_attempts * attempt_cycles + 2 * success_cycles + 16;
   localparam int n_random  = 10;
   localparam int max_gap   = 16;
   localparam int watchdog_cycles = 5 + (6 + n_random) * (req_bound + max_gap + 16);

   logic              clk = 1'b0;
   logic              arst_n;
   logic              tx_req_a;
   logic              tx_req_b;
   logic              rx_ack_a;
   logic              rx_ack_b;
   csma_pkg::status_t tx_status_a;
   csma_pkg::status_t tx_status_b;
   logic              rx_ready_a;
   logic              rx_ready_b;
   logic              carrier_sense;
   logic              collision_detect;

   int   cycle_count = 0;
   // event counts since the last open_window
   int   ok_a, fail_a, rise_a;
   int   ok_b, fail_b, rise_b;
   int   coll_rises;
   logic ready_a_q = 1'b0;
   logic ready_b_q = 1'b0;
   logic coll_q    = 1'b0;
   bit   auto_ack  = 1'b0;
   int   gaps_a [n_random];
   int   gaps_b [n_random];

   `include "tb_checks.svh"

   csma_link_top uut (.*);

   always #(clk_period / 2) clk = ~clk;

   always @(posedge clk)
      cycle_count++;

   // status pulses, rx_ready rises and collisions, sampled mid-cycle
   always @(negedge clk)
   begin
      if (arst_n)
      begin
         if (tx_status_a == csma_pkg::st_success)
            ok_a++;
         else if (tx_status_a == csma_pkg::st_fail)
            fail_a++;
         if (tx_status_b == csma_pkg::st_success)
            ok_b++;
         else if (tx_status_b == csma_pkg::st_fail)
            fail_b++;
         if (rx_ready_a && !ready_a_q)
            rise_a++;
         if (rx_ready_b && !ready_b_q)
            rise_b++;
         if (collision_detect && !coll_q)
            coll_rises++;
         ready_a_q = rx_ready_a;
         ready_b_q = rx_ready_b;
         coll_q    = collision_detect;
         // host takes every frame at once, one-cycle ack pulse
         if (auto_ack)
         begin
            rx_ack_a = rx_ready_a && !rx_ack_a;
            rx_ack_b = rx_ready_b && !rx_ack_b;
         end
      end
   end

   initial
   begin
      #(watchdog_cycles * clk_period);
      $display("run stopped after %0d cycles, a test never finished (checks %0d, errors %0d)",
               watchdog_cycles, check_count, value_errors + other_errors);
      $display("CHECKS FAILED");
      $finish;
   end

   task automatic wait_falling_edges(input int n);
      repeat (n) @(negedge clk);
   endtask

   // counters restart on a rising edge, clear of the monitor
   task automatic open_window(input bit ack_on);
      @(posedge clk);
      ok_a       = 0;
      fail_a     = 0;
      rise_a     = 0;
      ok_b       = 0;
      fail_b     = 0;
      rise_b     = 0;
      coll_rises = 0;
      auto_ack   = ack_on;
      @(negedge clk);
   endtask

   // one request held until its status, dropped on the same falling edge
   task automatic send_request(input bit from_b, input string test,
                               output csma_pkg::status_t st, output int latency,
                               output int stamp);
      int start;
      @(negedge clk);
      start = cycle_count;
      st    = csma_pkg::st_none;
      if (from_b)
         tx_req_b = 1'b1;
      else
         tx_req_a = 1'b1;
      while (st == csma_pkg::st_none && cycle_count - start < req_bound)
      begin
         @(negedge clk);
         st = from_b ? tx_status_b : tx_status_a;
      end
      stamp   = cycle_count;
      latency = stamp - start;
      if (from_b)
         tx_req_b = 1'b0;
      else
         tx_req_a = 1'b0;
      if (st == csma_pkg::st_none)
      begin
         other_errors++;
         $display("[%s] station %s got no transmit status within %0d cycles",
                  test, from_b ? "b" : "a", req_bound);
      end
   endtask

   task automatic after_reset_test();
      @(negedge clk);
      compare_status("after reset", "tx_status_a", csma_pkg::st_none, tx_status_a);
      compare_status("after reset", "tx_status_b", csma_pkg::st_none, tx_status_b);
      compare_bit("after reset", "rx_ready_a", 1'b0, rx_ready_a);
      compare_bit("after reset", "rx_ready_b", 1'b0, rx_ready_b);
      compare_bit("after reset", "carrier_sense", 1'b0, carrier_sense);
      compare_bit("after reset", "collision_detect", 1'b0, collision_detect);
   endtask

   task automatic uncontended_send();
      csma_pkg::status_t st;
      int latency;
      int stamp;
      open_window(1'b0);
      send_request(1'b0, "uncontended", st, latency, stamp);
      compare_status("uncontended", "status a", csma_pkg::st_success, st);
      compare_count("uncontended", "latency a", success_cycles, latency);
      wait_falling_edges(4);
      @(posedge clk);
      compare_count("uncontended", "rx_ready_b rises", 1, rise_b);
      compare_count("uncontended", "rx_ready_a rises", 0, rise_a);
      compare_count("uncontended", "collision rises", 0, coll_rises);
   endtask

   // frame from a is already waiting at b unless b sends first
   task automatic acknowledge_hold(input bit from_b, input string test);
      csma_pkg::status_t st;
      int latency;
      int stamp;
      int i;
      if (from_b)
      begin
         open_window(1'b0);
         send_request(1'b1, test, st, latency, stamp);
         compare_status(test, "status b", csma_pkg::st_success, st);
      end
      for (i = 0; i < 6; i++)
      begin
         @(negedge clk);
         compare_bit(test, "rx_ready before ack", 1'b1, from_b ? rx_ready_a : rx_ready_b);
      end
      if (from_b)
         rx_ack_a = 1'b1;
      else
         rx_ack_b = 1'b1;
      @(negedge clk);
      compare_bit(test, "rx_ready after ack", 1'b0, from_b ? rx_ready_a : rx_ready_b);
      rx_ack_a = 1'b0;
      rx_ack_b = 1'b0;
   endtask

   task automatic simultaneous_requests();
      csma_pkg::status_t st_a;
      csma_pkg::status_t st_b;
      int lat_a, lat_b;
      int stamp_a, stamp_b;
      open_window(1'b1);
      fork
         send_request(1'b0, "simultaneous", st_a, lat_a, stamp_a);
         send_request(1'b1, "simultaneous", st_b, lat_b, stamp_b);
      join
      wait_falling_edges(4);
      @(posedge clk);
      compare_bit("simultaneous", "collision seen", 1'b1, coll_rises > 0);
      compare_count("simultaneous", "statuses a", 1, ok_a + fail_a);
      compare_count("simultaneous", "statuses b", 1, ok_b + fail_b);
      // a failed frame must leave the far receiver untouched
      compare_count("simultaneous", "frames at b", ok_a, rise_b);
      compare_count("simultaneous", "frames at a", ok_b, rise_a);
   endtask

   task automatic deferred_request();
      csma_pkg::status_t st_a;
      csma_pkg::status_t st_b;
      int lat_a, lat_b;
      int stamp_a, stamp_b;
      int waited;
      open_window(1'b1);
      waited = 0;
      fork
         send_request(1'b0, "deferral", st_a, lat_a, stamp_a);
         begin
            // b asks only once a's frame is on the channel
            while (!carrier_sense && waited < req_bound)
            begin
               @(negedge clk);
               waited++;
            end
            send_request(1'b1, "deferral", st_b, lat_b, stamp_b);
         end
      join
      wait_falling_edges(4);
      @(posedge clk);
      compare_status("deferral", "status a", csma_pkg::st_success, st_a);
      compare_status("deferral", "status b", csma_pkg::st_success, st_b);
      compare_bit("deferral", "b reports after a", 1'b1, stamp_b > stamp_a);
      compare_count("deferral", "collision rises", 0, coll_rises);
      compare_count("deferral", "frames at b", 1, rise_b);
      compare_count("deferral", "frames at a", 1, rise_a);
   endtask

   // n_random requests from one station with idle gaps in between
   task automatic station_traffic(input bit from_b, output int successes);
      csma_pkg::status_t st;
      int latency;
      int stamp;
      int i;
      successes = 0;
      for (i = 0; i < n_random; i++)
      begin
         repeat (from_b ? gaps_b[i] : gaps_a[i]) @(negedge clk);
         send_request(from_b, "random", st, latency, stamp);
         if (st == csma_pkg::st_success)
            successes++;
      end
   endtask

   task automatic random_traffic();
      int succ_a;
      int succ_b;
      int i;
      // gaps drawn up front, both stations then run in parallel
      for (i = 0; i < n_random; i++)
      begin
         gaps_a[i] = random_bits(4);
         gaps_b[i] = random_bits(4);
      end
      open_window(1'b1);
      fork
         station_traffic(1'b0, succ_a);
         station_traffic(1'b1, succ_b);
      join
      wait_falling_edges(4);
      @(posedge clk);
      compare_count("random", "statuses a", n_random, ok_a + fail_a);
      compare_count("random", "statuses b", n_random, ok_b + fail_b);
      compare_count("random", "successes a", succ_a, ok_a);
      compare_count("random", "successes b", succ_b, ok_b);
      compare_count("random", "frames at b", ok_a, rise_b);
      compare_count("random", "frames at a", ok_b, rise_a);
   endtask

   initial
   begin
      arst_n   = 1'b0;
      tx_req_a = 1'b0;
      tx_req_b = 1'b0;
      rx_ack_a = 1'b0;
      rx_ack_b = 1'b0;
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      after_reset_test();
      uncontended_send();
      acknowledge_hold(1'b0, "acknowledge a to b");
      acknowledge_hold(1'b1, "acknowledge b to a");
      simultaneous_requests();
      deferred_request();
      random_traffic();
      $display("checks %0d, value errors %0d, other failures %0d",
               check_count, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* logic/csma_link_top.sv */
//////////////////////////////////////////////////////////////////////
// two-station csma/cd link
// stations a and b on one shared channel
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module csma_link_top #(
   parameter int FRAME_LEN     = csma_pkg::frame_len_default,
   parameter int MAX_ATTEMPTS  = csma_pkg::max_attempts_default,
   parameter int SETTLE_CYCLES = csma_pkg::settle_cycles_default
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              tx_req_a,
   input  logic              tx_req_b,
   input  logic              rx_ack_a,
   input  logic              rx_ack_b,
   output csma_pkg::status_t tx_status_a,
   output csma_pkg::status_t tx_status_b,
   output logic              rx_ready_a,
   output logic              rx_ready_b,
   output logic              carrier_sense,
   output logic              collision_detect
);

   csma_pkg::symbol_t line_a;
   csma_pkg::symbol_t line_b;
   csma_pkg::symbol_t line_in;

   // seeds differ so the stations pick different backoff delays
   csma_station #(
      .FRAME_LEN     (FRAME_LEN),
      .MAX_ATTEMPTS  (MAX_ATTEMPTS),
      .SETTLE_CYCLES (SETTLE_CYCLES),
      .BACKOFF_SEED  (16'hace1)
   ) station_a (
      .clk              (clk),
      .arst_n           (arst_n),
      .tx_req           (tx_req_a),
      .rx_ack           (rx_ack_a),
      .carrier_sense    (carrier_sense),
      .collision_detect (collision_detect),
      .line_in          (line_in),
      .line_out         (line_a),
      .tx_status        (tx_status_a),
      .rx_ready         (rx_ready_a)
   );

   csma_station #(
      .FRAME_LEN     (FRAME_LEN),
      .MAX_ATTEMPTS  (MAX_ATTEMPTS),
      .SETTLE_CYCLES (SETTLE_CYCLES),
      .BACKOFF_SEED  (16'h5a3c)
   ) station_b (
      .clk              (clk),
      .arst_n           (arst_n),
      .tx_req           (tx_req_b),
      .rx_ack           (rx_ack_b),
      .carrier_sense    (carrier_sense),
      .collision_detect (collision_detect),
      .line_in          (line_in),
      .line_out         (line_b),
      .tx_status        (tx_status_b),
      .rx_ready         (rx_ready_b)
   );

   channel_model u_channel (
      .clk              (clk),
      .arst_n           (arst_n),
      .line_a           (line_a),
      .line_b           (line_b),
      .line_in          (line_in),
      .carrier_sense    (carrier_sense),
      .collision_detect (collision_detect)
   );

endmodule

/* logic/csma_station.sv */
//////////////////////////////////////////////////////////////////////
// one csma/cd station
// transmit fsm, backoff timer, bit transmitter, frame receiver,
// shared symbol counter and own-transmission receive blanking
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module csma_station #(
   parameter int          FRAME_LEN     = 4,
   parameter int          MAX_ATTEMPTS  = 3,
   parameter int          SETTLE_CYCLES = 4,
   parameter logic [15:0] BACKOFF_SEED  = 16'hace1
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              tx_req,
   input  logic              rx_ack,
   input  logic              carrier_sense,
   input  logic              collision_detect,
   input  csma_pkg::symbol_t line_in,
   output csma_pkg::symbol_t line_out,
   output csma_pkg::status_t tx_status,
   output logic              rx_ready
);

   localparam int cnt_max = (FRAME_LEN > SETTLE_CYCLES) ? FRAME_LEN : SETTLE_CYCLES;
   localparam int cnt_w   = $clog2(cnt_max + 1);

   csma_pkg::symbol_t   tx_symbol;
   csma_pkg::tx_state_t tx_state;
   logic                burst_done;
   logic                collision_seen;
   logic                attempts_clear;
   logic                last_attempt;
   logic                backoff_busy;
   logic [cnt_w-1:0]    sym_cnt;
   logic                sym_cnt_clr;
   logic                own_busy;
   logic                rx_carrier;

   // frame-in-progress counter, symbols in send/jam and cycles in settle
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         sym_cnt  <= '0;
         own_busy <= 1'b0;
      end
      else
      begin
         if (sym_cnt_clr)
            sym_cnt <= '0;
         else if (sym_cnt != {cnt_w{1'b1}})
            sym_cnt <= sym_cnt + 1'b1;
         // lines up with our own symbols coming back from the channel
         own_busy <= (line_out != csma_pkg::sym_none);
      end
   end

   // receiver stays deaf to our own frame
   assign rx_carrier = carrier_sense && !own_busy;

   frame_tx_fsm #(
      .FRAME_LEN     (FRAME_LEN),
      .SETTLE_CYCLES (SETTLE_CYCLES),
      .CNT_W         (cnt_w)
   ) u_fsm (
      .clk              (clk),
      .arst_n           (arst_n),
      .tx_req           (tx_req),
      .carrier_sense    (carrier_sense),
      .collision_detect (collision_detect),
      .burst_done       (burst_done),
      .backoff_busy     (backoff_busy),
      .last_attempt     (last_attempt),
      .sym_cnt          (sym_cnt),
      .tx_symbol        (tx_symbol),
      .tx_status        (tx_status),
      .tx_state         (tx_state),
      .collision_seen   (collision_seen),
      .attempts_clear   (attempts_clear),
      .sym_cnt_clr      (sym_cnt_clr)
   );

   backoff_timer #(
      .MAX_ATTEMPTS (MAX_ATTEMPTS),
      .BACKOFF_SEED (BACKOFF_SEED)
   ) u_backoff (
      .clk            (clk),
      .arst_n         (arst_n),
      .collision_seen (collision_seen),
      .attempts_clear (attempts_clear),
      .tx_state       (tx_state),
      .backoff_busy   (backoff_busy),
      .last_attempt   (last_attempt)
   );

   bit_transmitter u_bit_tx (
      .clk        (clk),
      .arst_n     (arst_n),
      .tx_symbol  (tx_symbol),
      .line_out   (line_out),
      .burst_done (burst_done)
   );

   frame_receiver #(
      .FRAME_LEN (FRAME_LEN)
   ) u_rx (
      .clk           (clk),
      .arst_n        (arst_n),
      .carrier_sense (rx_carrier),
      .rx_ack        (rx_ack),
      .line_in       (line_in),
      .rx_ready      (rx_ready)
   );

endmodule

/* logic/channel_model.sv */
//////////////////////////////////////////////////////////////////////
// shared channel
// registered merge of both station lines,
// carrier sense and collision detect
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module channel_model (
   input  logic              clk,
   input  logic              arst_n,
   input  csma_pkg::symbol_t line_a,
   input  csma_pkg::symbol_t line_b,
   output csma_pkg::symbol_t line_in,
   output logic              carrier_sense,
   output logic              collision_detect
);

   logic a_busy;
   logic b_busy;
   logic any_jam;

   assign a_busy  = (line_a != csma_pkg::sym_none);
   assign b_busy  = (line_b != csma_pkg::sym_none);
   assign any_jam = (line_a == csma_pkg::sym_jam) || (line_b == csma_pkg::sym_jam);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         line_in          <= csma_pkg::sym_none;
         carrier_sense    <= 1'b0;
         collision_detect <= 1'b0;
      end
      else
      begin
         // both driving garbles the line into a jam
         if (!a_busy)
            line_in <= line_b;
         else if (!b_busy)
            line_in <= line_a;
         else
            line_in <= csma_pkg::sym_jam;
         carrier_sense    <= a_busy || b_busy;
         collision_detect <= (a_busy && b_busy) || any_jam;
      end
   end

endmodule

/* logic/frame_receiver.sv */
//////////////////////////////////////////////////////////////////////
// frame receiver
// samples the channel while carrier is up plus one cycle,
// counts frame symbols and holds rx_ready until acknowledged
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module frame_receiver #(
   parameter int FRAME_LEN = 4
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              carrier_sense,
   input  logic              rx_ack,
   input  csma_pkg::symbol_t line_in,
   output logic              rx_ready
);

   // room for one symbol past a full frame, marks an overlong run
   localparam int run_w = $clog2(FRAME_LEN + 2);

   logic              cs_q;
   logic              sample_en;
   csma_pkg::symbol_t rx_sym;
   logic [run_w-1:0]  run_cnt;
   logic              good_end;

   // carrier window stretched by one cycle to catch the trailing idle
   assign sample_en = carrier_sense || cs_q;
   assign good_end  = (rx_sym == csma_pkg::sym_none) && (run_cnt == run_w'(FRAME_LEN));

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cs_q     <= 1'b0;
         rx_sym   <= csma_pkg::sym_none;
         run_cnt  <= '0;
         rx_ready <= 1'b0;
      end
      else
      begin
         cs_q   <= carrier_sense;
         // outside the window the line reads as idle
         rx_sym <= sample_en ? line_in : csma_pkg::sym_none;
         // jam or idle breaks the run
         if (rx_sym == csma_pkg::sym_frame)
         begin
            if (run_cnt != run_w'(FRAME_LEN + 1))
               run_cnt <= run_cnt + 1'b1;
         end
         else
            run_cnt <= '0;
         // a new good frame wins over an ack in the same cycle
         if (good_end)
            rx_ready <= 1'b1;
         else if (rx_ack)
            rx_ready <= 1'b0;
      end
   end

endmodule

/* logic/bit_transmitter.sv */
//////////////////////////////////////////////////////////////////////
// bit transmitter
// registers the state machine's symbols onto the station line
// and pulses burst_done when a burst ends
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module bit_transmitter (
   input  logic              clk,
   input  logic              arst_n,
   input  csma_pkg::symbol_t tx_symbol,
   output csma_pkg::symbol_t line_out,
   output logic              burst_done
);

   logic line_busy;

   // something was on the line last cycle
   assign line_busy = (line_out != csma_pkg::sym_none);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         line_out   <= csma_pkg::sym_none;
         burst_done <= 1'b0;
      end
      else
      begin
         line_out   <= tx_symbol;
         // first idle after a frame or jam run
         burst_done <= line_busy && (tx_symbol == csma_pkg::sym_none);
      end
   end

endmodule

/* logic/frame_tx_fsm.sv */
//////////////////////////////////////////////////////////////////////
// frame transmitter state machine
// defers on carrier, sends a frame, jams on collision,
// waits out backoff or settle time, reports success or failure
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module frame_tx_fsm #(
   parameter int FRAME_LEN     = 4,
   parameter int SETTLE_CYCLES = 4,
   parameter int CNT_W         = 3
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                tx_req,
   input  logic                carrier_sense,
   input  logic                collision_detect,
   input  logic                burst_done,
   input  logic                backoff_busy,
   input  logic                last_attempt,
   input  logic [CNT_W-1:0]    sym_cnt,
   output csma_pkg::symbol_t   tx_symbol,
   output csma_pkg::status_t   tx_status,
   output csma_pkg::tx_state_t tx_state,
   output logic                collision_seen,
   output logic                attempts_clear,
   output logic                sym_cnt_clr
);

   localparam logic [CNT_W-1:0] last_sym    = CNT_W'(FRAME_LEN - 1);
   localparam logic [CNT_W-1:0] last_settle = CNT_W'(SETTLE_CYCLES - 1);

   csma_pkg::tx_state_t state;
   csma_pkg::tx_state_t state_next;
   // current attempt ended in a jam
   logic                jammed_q;

   always_comb
   begin
      state_next     = state;
      sym_cnt_clr    = 1'b0;
      collision_seen = 1'b0;
      case (state)
         csma_pkg::tx_idle:
         begin
            // defer while anything is on the line
            if (tx_req && !carrier_sense && !collision_detect)
            begin
               state_next  = csma_pkg::tx_send;
               sym_cnt_clr = 1'b1;
            end
         end
         csma_pkg::tx_send,
         csma_pkg::tx_wait_end,
         csma_pkg::tx_settle:
         begin
            // collision while our frame may still be in flight
            if (collision_detect && !jammed_q)
            begin
               state_next     = csma_pkg::tx_jam;
               sym_cnt_clr    = 1'b1;
               collision_seen = 1'b1;
            end
            else if (state == csma_pkg::tx_send)
            begin
               if (sym_cnt == last_sym)
                  state_next = csma_pkg::tx_wait_end;
            end
            else if (state == csma_pkg::tx_settle)
            begin
               if (sym_cnt == last_settle)
                  state_next = csma_pkg::tx_report;
            end
            else if (burst_done)
            begin
               if (!jammed_q)
               begin
                  state_next  = csma_pkg::tx_settle;
                  sym_cnt_clr = 1'b1;
               end
               else if (last_attempt)
                  state_next = csma_pkg::tx_report;
               else
                  state_next = csma_pkg::tx_backoff;
            end
         end
         csma_pkg::tx_jam:
         begin
            if (sym_cnt == last_sym)
               state_next = csma_pkg::tx_wait_end;
         end
         csma_pkg::tx_backoff:
         begin
            if (!backoff_busy)
               state_next = csma_pkg::tx_idle;
         end
         // report lasts one cycle, tx_req not looked at
         default:
            state_next = csma_pkg::tx_idle;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= csma_pkg::tx_idle;
         jammed_q <= 1'b0;
      end
      else
      begin
         state <= state_next;
         if (collision_seen)
            jammed_q <= 1'b1;
         else if (state == csma_pkg::tx_idle)
            jammed_q <= 1'b0;
      end
   end

   always_comb
   begin
      case (state)
         csma_pkg::tx_send: tx_symbol = csma_pkg::sym_frame;
         csma_pkg::tx_jam:  tx_symbol = csma_pkg::sym_jam;
         default:           tx_symbol = csma_pkg::sym_none;
      endcase
   end

   // a report after a jam is always the give-up case
   assign tx_status = (state != csma_pkg::tx_report) ? csma_pkg::st_none :
                      jammed_q ? csma_pkg::st_fail : csma_pkg::st_success;
   assign attempts_clear = (state == csma_pkg::tx_report);
   assign tx_state       = state;

endmodule

/* logic/backoff_timer.sv */
//////////////////////////////////////////////////////////////////////
// backoff timer for one station
// collision counter with attempt limit, free-running lfsr,
// backoff delay load and countdown
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module backoff_timer #(
   parameter int          MAX_ATTEMPTS = 3,
   parameter logic [15:0] BACKOFF_SEED = 16'hace1
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                collision_seen,
   input  logic                attempts_clear,
   input  csma_pkg::tx_state_t tx_state,
   output logic                backoff_busy,
   output logic                last_attempt
);

   localparam int coll_w = $clog2(MAX_ATTEMPTS + 1);

   logic [coll_w-1:0] coll_cnt;
   logic [15:0]       lfsr;
   logic [2:0]        delay_cnt;
   logic [2:0]        win_mask;

   // window grows by one bit per collision, capped at 3 bits (7 cycles)
   always_comb
   begin
      if (coll_cnt == coll_w'(0))
         win_mask = 3'b001;
      else if (coll_cnt == coll_w'(1))
         win_mask = 3'b011;
      else
         win_mask = 3'b111;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         coll_cnt  <= '0;
         lfsr      <= BACKOFF_SEED;
         delay_cnt <= 3'd0;
      end
      else
      begin
         // galois form, taps 16 14 13 11
         lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
         if (attempts_clear)
         begin
            coll_cnt  <= '0;
            delay_cnt <= 3'd0;
         end
         else if (collision_seen)
         begin
            if (!last_attempt)
               coll_cnt <= coll_cnt + 1'b1;
            delay_cnt <= lfsr[2:0] & win_mask;
         end
         // delay only runs once the jam burst is over
         else if (tx_state == csma_pkg::tx_backoff && delay_cnt != 3'd0)
            delay_cnt <= delay_cnt - 1'b1;
      end
   end

   assign backoff_busy = (delay_cnt != 3'd0);
   assign last_attempt = (coll_cnt >= coll_w'(MAX_ATTEMPTS));

endmodule

/* logic/csma_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types for the two-station csma/cd link
// channel symbol, transmit outcome and transmitter state enums
// default frame length, attempt limit and settle time
//////////////////////////////////////////////////////////////////////

package csma_pkg;

   // symbol on a station line or the merged channel
   // sym_none is an idle line
   typedef enum logic [1:0]
   {
      sym_jam   = 2'd0,
      sym_frame = 2'd1,
      sym_none  = 2'd2
   } symbol_t;

   // one-cycle outcome reported to the host
   typedef enum logic [1:0]
   {
      st_fail    = 2'd0,
      st_success = 2'd1,
      st_none    = 2'd2
   } status_t;

   // frame transmitter states
   typedef enum logic [2:0]
   {
      tx_idle     = 3'd0,
      tx_send     = 3'd1,
      tx_jam      = 3'd2,
      tx_wait_end = 3'd3,
      tx_settle   = 3'd4,
      tx_backoff  = 3'd5,
      tx_report   = 3'd6
   } tx_state_t;

   // frame symbols per frame
   localparam int frame_len_default = 4;
   // collisions before a request fails
   localparam int max_attempts_default = 3;
   // quiet cycles after a burst, covers the channel round trip
   localparam int settle_cycles_default = 4;

endpackage
